// File: list.f
+incdir+source
source/core_pkg.sv
source/core_ctrl_if.sv
source/core_result_if.sv
source/core_decode.sv
source/core_timing.sv
source/core_execute.sv
source/core_result.sv
source/core_6502.sv
verif/tb_core_6502.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_core_6502 -Mdir obj_dir

# a failing run still leaves its log for the search below
./obj_dir/Vtb_core_6502 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
else
    echo "run.sh: simulation did not pass"
    exit 1
fi

// File: verif/tb_core_6502.sv
`include "core_config.svh"

module tb_core_6502;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk_m1;
    logic        rst;
    logic [7:0]  data_i;
    logic        ready_i;
    logic [15:0] addr_o;
    logic [7:0]  dor_o;
    logic        rw_o;
    logic        sync_o;
    logic        jam_o;

    // 64 KiB memory seen by the core
    logic [7:0]  mem [0:65535];
    int          cyc;
    bit          run_on;
    bit          stall_en;
    bit          prev_stall;
    logic [15:0] prev_addr;
    int          stall_cnt;
    logic [31:0] prog_seed;
    logic [31:0] rdy_seed;

    // bus activity seen during a run
    logic [15:0] wr_addr [$];
    logic [7:0]  wr_data [$];
    int          wr_cyc [$];
    logic [15:0] sync_addr [$];
    int          sync_cyc [$];

    // expectations built together with the program
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          exp_cyc [$];
    logic [15:0] exp_sync_addr [$];
    int          exp_sync_cyc [$];
    logic [15:0] pc_build;
    int          clk_build;

    // stall-free writes of the ALU program
    logic [15:0] ref_addr [$];
    logic [7:0]  ref_data [$];

    core_6502 core_6502_i (
        .clk_m1  (clk_m1),
        .rst     (rst),
        .data_i  (data_i),
        .ready_i (ready_i),
        .addr_o  (addr_o),
        .dor_o   (dor_o),
        .rw_o    (rw_o),
        .sync_o  (sync_o),
        .jam_o   (jam_o)
    );

    initial begin
        clk_m1 = 1'b0;
        forever #50 clk_m1 = ~clk_m1;
    end

    always @(posedge clk_m1) cyc <= cyc + 1;

    // one step of the 32-bit LCG
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function logic [7:0] next_rand();
        prog_seed = lcg_next(prog_seed);
        return prog_seed[23:16];
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("FAIL @%0t: %s, got %0h expected %0h", $time, msg, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at time %0t", why, $time);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // memory model, answers from the registered address
    always @(negedge clk_m1) begin
        if (run_on) begin
            // a stalled read must repeat the same address
            if (prev_stall) check(32'(addr_o), 32'(prev_addr), "address moved during stall");
            if (rw_o == 1'b0) begin
                mem[addr_o] = dor_o;
                wr_addr.push_back(addr_o);
                wr_data.push_back(dor_o);
                wr_cyc.push_back(cyc);
            end
            // a repeated fetch counts once
            if (sync_o == 1'b1 && !prev_stall) begin
                sync_addr.push_back(addr_o);
                sync_cyc.push_back(cyc);
            end
        end
        data_i = mem[addr_o];
        ready_i = 1'b1;
        if (stall_en) begin
            rdy_seed = lcg_next(rdy_seed);
            // roughly one read in four held off
            ready_i = rdy_seed[20] | rdy_seed[21];
        end
        prev_stall = run_on && !ready_i && (rw_o === 1'b1);
        if (prev_stall) stall_cnt++;
        prev_addr = addr_o;
    end

    task automatic clear_prog();
        for (int i = 0; i < 65536; i++) begin
            mem[16'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
        end
        pc_build = `CORE_RESET_PC;
        clk_build = 0;
        exp_addr.delete();
        exp_data.delete();
        exp_cyc.delete();
        exp_sync_addr.delete();
        exp_sync_cyc.delete();
    endtask

    task automatic put_byte(input logic [7:0] b);
        mem[pc_build] = b;
        pc_build = pc_build + 16'd1;
    endtask

    // each emitter knows its length and clock count
    task automatic instr_impl(input logic [7:0] op);
        exp_sync_addr.push_back(pc_build);
        exp_sync_cyc.push_back(clk_build);
        put_byte(op);
        clk_build += 2;
    endtask

    task automatic instr_imm(input logic [7:0] op, input logic [7:0] v);
        exp_sync_addr.push_back(pc_build);
        exp_sync_cyc.push_back(clk_build);
        put_byte(op);
        put_byte(v);
        clk_build += 2;
    endtask

    task automatic instr_zpg(input logic [7:0] op, input logic [7:0] zp);
        exp_sync_addr.push_back(pc_build);
        exp_sync_cyc.push_back(clk_build);
        put_byte(op);
        put_byte(zp);
        clk_build += 3;
    endtask

    task automatic instr_abs(input logic [7:0] op, input logic [15:0] ad);
        exp_sync_addr.push_back(pc_build);
        exp_sync_cyc.push_back(clk_build);
        put_byte(op);
        put_byte(ad[7:0]);
        put_byte(ad[15:8]);
        clk_build += 4;
    endtask

    // write lands in the last clock of the store
    task automatic store_zpg(input logic [7:0] op, input logic [7:0] zp, input logic [7:0] v);
        exp_addr.push_back({8'h00, zp});
        exp_data.push_back(v);
        exp_cyc.push_back(clk_build + 2);
        instr_zpg(op, zp);
    endtask

    task automatic store_abs(input logic [7:0] op, input logic [15:0] ad, input logic [7:0] v);
        exp_addr.push_back(ad);
        exp_data.push_back(v);
        exp_cyc.push_back(clk_build + 3);
        instr_abs(op, ad);
    endtask

    // ends the program with an unused opcode, resets and runs until jam
    task automatic run_prog(input bit stalls);
        int n;
        instr_impl(8'h02);
        run_on = 1'b0;
        stall_en = stalls;
        stall_cnt = 0;
        rdy_seed = 32'he061;
        rst = 1'b1;
        repeat (8) @(negedge clk_m1);
        wr_addr.delete();
        wr_data.delete();
        wr_cyc.delete();
        sync_addr.delete();
        sync_cyc.delete();
        check(32'(sync_o), 32'd0, "sync in reset state");
        check(32'(rw_o), 32'd1, "rw in reset state");
        check(32'(jam_o), 32'd0, "jam in reset state");
        check(32'(addr_o), 32'(`CORE_RESET_PC), "addr in reset state");
        rst = 1'b0;
        run_on = 1'b1;
        n = 0;
        while (jam_o !== 1'b1) begin
            @(negedge clk_m1);
            n++;
            if (n > 5000) abort_run("timeout waiting for jam_o");
        end
    endtask

    task automatic check_bus(input bit with_cycles);
        check(32'(sync_addr.size()), 32'(exp_sync_addr.size()), "sync count");
        for (int i = 0; i < exp_sync_addr.size(); i++) begin
            check(32'(sync_addr[i]), 32'(exp_sync_addr[i]), "sync address");
            if (with_cycles) begin
                check(32'(sync_cyc[i] - sync_cyc[0]), 32'(exp_sync_cyc[i]), "sync clock");
            end
        end
        check(32'(wr_addr.size()), 32'(exp_addr.size()), "write count");
        for (int i = 0; i < exp_addr.size(); i++) begin
            check(32'(wr_addr[i]), 32'(exp_addr[i]), "write address");
            check(32'(wr_data[i]), 32'(exp_data[i]), "write data");
            if (with_cycles) begin
                check(32'(wr_cyc[i] - sync_cyc[0]), 32'(exp_cyc[i]), "write clock");
            end
        end
    endtask

    task automatic test_sync_order();
        clear_prog();
        instr_impl(8'hEA);
        instr_imm(8'hA9, 8'h01);
        instr_impl(8'hEA);
        instr_imm(8'hA2, 8'h02);
        instr_imm(8'hA0, 8'h03);
        instr_impl(8'hEA);
        run_prog(1'b0);
        check_bus(1'b1);
    endtask

    task automatic test_load_store();
        clear_prog();
        mem[16'h0020] = 8'h5C;
        mem[16'h0021] = 8'hA5;
        mem[16'h1234] = 8'hC3;
        mem[16'h1235] = 8'h7E;
        instr_imm(8'hA9, 8'h11);
        store_zpg(8'h85, 8'h30, 8'h11);
        instr_zpg(8'hA6, 8'h20);
        store_abs(8'h8E, 16'h4000, 8'h5C);
        instr_abs(8'hAC, 16'h1234);
        store_zpg(8'h84, 8'h31, 8'hC3);
        instr_abs(8'hAD, 16'h1235);
        store_abs(8'h8D, 16'h4001, 8'h7E);
        instr_imm(8'hA2, 8'h99);
        store_zpg(8'h86, 8'h32, 8'h99);
        instr_zpg(8'hA4, 8'h21);
        store_abs(8'h8C, 16'h4002, 8'hA5);
        instr_imm(8'hA0, 8'h0F);
        store_abs(8'h8C, 16'h4003, 8'h0F);
        run_prog(1'b0);
        check_bus(1'b1);
    endtask

    // 6502 rules, bit 8 of the return value is the carry
    function automatic int model_alu(input int op, input int a, input int b, input int c);
        int s;
        case (op)
            0: return (c << 8) | (a | b);
            1: return (c << 8) | (a & b);
            2: return (c << 8) | (a ^ b);
            3: return a + b + c;
            default: begin
                // borrow when the difference goes negative
                s = a - b - (1 - c);
                if (s < 0) return s + 256;
                return 256 | s;
            end
        endcase
    endfunction

    task automatic test_alu(input bit stalls);
        logic [7:0] base [5];
        logic [7:0] r;
        logic [7:0] v;
        int         a;
        int         c;
        int         op;
        int         res;
        base = '{8'h09, 8'h29, 8'h49, 8'h69, 8'hE9};
        clear_prog();
        prog_seed = 32'he061;
        v = next_rand();
        instr_imm(8'hA9, v);
        a = int'(v);
        c = 0;
        for (int k = 0; k < 12; k++) begin
            r = next_rand();
            c = r[0] ? 0 : 1;
            instr_impl(r[0] ? 8'h18 : 8'h38);
            op = int'(next_rand()) % 5;
            v = next_rand();
            r = next_rand();
            case (int'(r) % 3)
                0: instr_imm(base[3'(op)], v);
                1: begin
                    mem[16'h0010 + 16'(k)] = v;
                    instr_zpg(base[3'(op)] - 8'h04, 8'h10 + 8'(k));
                end
                default: begin
                    mem[16'h3000 + 16'(k)] = v;
                    instr_abs(base[3'(op)] + 8'h04, 16'h3000 + 16'(k));
                end
            endcase
            res = model_alu(op, a, int'(v), c);
            a = res & 255;
            c = (res >> 8) & 1;
            store_zpg(8'h85, 8'h40 + 8'(k), 8'(a));
            // carry read back through A = 0 + 0 + C
            instr_imm(8'hA9, 8'h00);
            instr_imm(8'h69, 8'h00);
            store_zpg(8'h85, 8'h60 + 8'(k), 8'(c));
            c = 0;
            instr_zpg(8'hA5, 8'h40 + 8'(k));
        end
        run_prog(stalls);
        check_bus(!stalls);
    endtask

    task automatic test_reg_ops();
        clear_prog();
        instr_imm(8'hA9, 8'h00);
        instr_impl(8'hAA);
        instr_impl(8'hCA);
        store_zpg(8'h86, 8'h50, 8'hFF);
        instr_impl(8'hE8);
        store_zpg(8'h86, 8'h51, 8'h00);
        instr_imm(8'hA0, 8'hFF);
        instr_impl(8'hC8);
        store_zpg(8'h84, 8'h52, 8'h00);
        instr_impl(8'h88);
        store_zpg(8'h84, 8'h53, 8'hFF);
        instr_impl(8'h98);
        store_zpg(8'h85, 8'h54, 8'hFF);
        instr_imm(8'hA9, 8'h3C);
        instr_impl(8'hA8);
        store_zpg(8'h84, 8'h55, 8'h3C);
        instr_imm(8'hA2, 8'h81);
        instr_impl(8'h8A);
        store_abs(8'h8D, 16'h4010, 8'h81);
        run_prog(1'b0);
        check_bus(1'b1);
    endtask

    task automatic test_jam();
        int n_wr;
        int n_sync;
        clear_prog();
        instr_imm(8'hA9, 8'h05);
        run_prog(1'b0);
        n_wr = wr_addr.size();
        n_sync = sync_addr.size();
        repeat (20) @(negedge clk_m1);
        check(32'(jam_o), 32'd1, "jam released");
        check(32'(wr_addr.size()), 32'(n_wr), "write after jam");
        check(32'(sync_addr.size()), 32'(n_sync), "sync after jam");
        check_bus(1'b1);
    endtask

    initial begin
        rst = 1'b1;
        data_i = 8'h00;
        ready_i = 1'b1;
        run_on = 1'b0;
        stall_en = 1'b0;
        prev_stall = 1'b0;
        prev_addr = 16'h0000;
        prog_seed = 32'he061;
        rdy_seed = 32'he061;
        test_sync_order();
        test_load_store();
        test_alu(1'b0);
        ref_addr = wr_addr;
        ref_data = wr_data;
        test_reg_ops();
        // same ALU program with stalled reads
        test_alu(1'b1);
        if (stall_cnt == 0) abort_run("no READY stall was applied");
        check(32'(wr_addr.size()), 32'(ref_addr.size()), "stalled write count");
        for (int i = 0; i < ref_addr.size(); i++) begin
            check(32'(wr_addr[i]), 32'(ref_addr[i]), "stalled write address");
            check(32'(wr_data[i]), 32'(ref_data[i]), "stalled write data");
        end
        test_jam();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: source/core_6502.sv
`include "core_config.svh"

module core_6502 (
    input  logic                    clk_m1,
    input  logic                    rst,
    input  logic [`CORE_DATA_W-1:0] data_i,
    input  logic                    ready_i,
    output logic [`CORE_ADDR_W-1:0] addr_o,
    output logic [`CORE_DATA_W-1:0] dor_o,
    output logic                    rw_o,
    output logic                    sync_o,
    output logic                    jam_o
);

    // decoded opcode fields
    core_ctrl_if   ctrl_if ();
    // write-back and register read-out
    core_result_if res_if ();

    logic                    fetch;
    logic                    exec;
    logic [`CORE_DATA_W-1:0] alu_out;

    core_decode core_decode_i (
        .clk_m1  (clk_m1),
        .rst     (rst),
        .data_i  (data_i),
        .ready_i (ready_i),
        .fetch_i (fetch),
        .ctrl    (ctrl_if)
    );

    core_timing core_timing_i (
        .clk_m1    (clk_m1),
        .rst       (rst),
        .data_i    (data_i),
        .ready_i   (ready_i),
        .alu_out_i (alu_out),
        .ctrl      (ctrl_if),
        .addr_o    (addr_o),
        .dor_o     (dor_o),
        .rw_o      (rw_o),
        .sync_o    (sync_o),
        .fetch_o   (fetch),
        .exec_o    (exec),
        .jam_o     (jam_o)
    );

    core_execute core_execute_i (
        .clk_m1    (clk_m1),
        .rst       (rst),
        .data_i    (data_i),
        .exec_i    (exec),
        .ctrl      (ctrl_if),
        .res       (res_if),
        .alu_out_o (alu_out)
    );

    core_result core_result_i (
        .clk_m1 (clk_m1),
        .rst    (rst),
        .res    (res_if)
    );

endmodule

// File: source/core_result.sv
`include "core_config.svh"

module core_result
    import core_pkg::*;
(
    input  logic          clk_m1,
    input  logic          rst,
    core_result_if.result res
);

    logic [`CORE_DATA_W-1:0] a_q;
    logic [`CORE_DATA_W-1:0] x_q;
    logic [`CORE_DATA_W-1:0] y_q;
    // only P bit kept
    logic                    c_q;

    // stores and NOPs arrive with REG_NONE
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            a_q <= '0;
            x_q <= '0;
            y_q <= '0;
            c_q <= 1'b0;
        end else if (res.wb_valid) begin
            case (res.wb_dst)
                REG_A:   a_q <= res.wb_value;
                REG_X:   x_q <= res.wb_value;
                REG_Y:   y_q <= res.wb_value;
                default: a_q <= a_q;
            endcase
            if (res.wb_carry_en) c_q <= res.wb_carry;
        end
    end

    // read back by execute for the next operand
    assign res.reg_a = a_q;
    assign res.reg_x = x_q;
    assign res.reg_y = y_q;
    assign res.carry = c_q;

endmodule

// File: source/core_execute.sv
`include "core_config.svh"

module core_execute
    import core_pkg::*;
(
    input  logic                    clk_m1,
    input  logic                    rst,
    input  logic [`CORE_DATA_W-1:0] data_i,
    input  logic                    exec_i,
    core_ctrl_if.execute            ctrl,
    core_result_if.execute          res,
    output logic [`CORE_DATA_W-1:0] alu_out_o
);

    localparam int DW = `CORE_DATA_W;

    logic [DW-1:0] op_a;
    logic [DW-1:0] op_b;
    // carry out in the top bit
    logic [DW:0]   sum;
    logic          carry_en;
    logic          carry_next;
    logic          wb_valid_q;
    reg_sel_t      wb_dst_q;
    logic [DW-1:0] wb_value_q;
    logic          wb_carry_en_q;
    logic          wb_carry_q;

    // no source register means the bus byte itself
    always_comb begin
        case (ctrl.src)
            REG_A:   op_a = res.reg_a;
            REG_X:   op_a = res.reg_x;
            REG_Y:   op_a = res.reg_y;
            default: op_a = data_i;
        endcase
    end

    assign op_b = data_i;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADC: sum = {1'b0, op_a} + {1'b0, op_b} + (DW+1)'(res.carry);
            // carry set means no borrow
            ALU_SBC: sum = {1'b0, op_a} + {1'b0, ~op_b} + (DW+1)'(res.carry);
            ALU_AND: sum = {1'b0, op_a & op_b};
            ALU_ORA: sum = {1'b0, op_a | op_b};
            ALU_EOR: sum = {1'b0, op_a ^ op_b};
            ALU_INC: sum = {1'b0, op_a + DW'(1)};
            ALU_DEC: sum = {1'b0, op_a - DW'(1)};
            default: sum = {1'b0, op_a};
        endcase
    end

    assign alu_out_o = sum[DW-1:0];

    // CLC/SEC override the adder carry
    assign carry_en   = ctrl.carry_set | ctrl.carry_clear |
                        (ctrl.alu_op == ALU_ADC) | (ctrl.alu_op == ALU_SBC);
    assign carry_next = ctrl.carry_set | (~ctrl.carry_clear & sum[DW]);

    always_ff @(posedge clk_m1) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= exec_i;
        end
    end

    // payload only meaningful alongside wb_valid
    always_ff @(posedge clk_m1) begin
        if (exec_i) begin
            wb_dst_q      <= ctrl.dst;
            wb_value_q    <= sum[DW-1:0];
            wb_carry_en_q <= carry_en;
            wb_carry_q    <= carry_next;
        end
    end

    assign res.wb_valid    = wb_valid_q;
    assign res.wb_dst      = wb_dst_q;
    assign res.wb_value    = wb_value_q;
    assign res.wb_carry_en = wb_carry_en_q;
    assign res.wb_carry    = wb_carry_q;

endmodule

// File: source/core_timing.sv
`include "core_config.svh"

module core_timing
    import core_pkg::*;
(
    input  logic                    clk_m1,
    input  logic                    rst,
    input  logic [`CORE_DATA_W-1:0] data_i,
    input  logic                    ready_i,
    input  logic [`CORE_DATA_W-1:0] alu_out_i,
    core_ctrl_if.timing             ctrl,
    output logic [`CORE_ADDR_W-1:0] addr_o,
    output logic [`CORE_DATA_W-1:0] dor_o,
    output logic                    rw_o,
    output logic                    sync_o,
    output logic                    fetch_o,
    output logic                    exec_o,
    output logic                    jam_o
);

    localparam int AW = `CORE_ADDR_W;
    localparam int DW = `CORE_DATA_W;

    cycle_t        state_q;
    cycle_t        state_d;
    logic [AW-1:0] pc_q;
    logic [AW-1:0] pc_d;
    logic [AW-1:0] addr_q;
    logic [AW-1:0] addr_d;
    // low byte of an absolute address
    logic [DW-1:0] adl_q;
    logic [DW-1:0] dor_q;
    logic          rw_q;
    logic          rdy;
    logic          is_store;
    logic          is_read;
    logic          exec_c;
    logic          wr_start;

    // write cycles never stall
    assign rdy      = ready_i | ~rw_q;
    assign is_store = (ctrl.op_class == CLS_STORE);
    assign is_read  = (ctrl.op_class == CLS_LOAD) || (ctrl.op_class == CLS_ALU);

    always_comb begin
        state_d  = state_q;
        pc_d     = pc_q;
        addr_d   = addr_q;
        exec_c   = 1'b0;
        wr_start = 1'b0;
        case (state_q)
            T1_FETCH: begin
                // opcode on the bus, step past it
                pc_d    = pc_q + AW'(1);
                addr_d  = pc_q + AW'(1);
                state_d = T2_OPER;
            end
            T2_OPER: begin
                if (ctrl.jam) begin
                    state_d = T_JAM;
                end else begin
                    case (ctrl.mode)
                        MODE_IMM: begin
                            exec_c  = 1'b1;
                            pc_d    = pc_q + AW'(1);
                            addr_d  = pc_q + AW'(1);
                            state_d = T1_FETCH;
                        end
                        MODE_ZPG: begin
                            // store data goes out with the zero-page address
                            exec_c   = is_store;
                            wr_start = is_store;
                            pc_d     = pc_q + AW'(1);
                            addr_d   = {{(AW-DW){1'b0}}, data_i};
                            state_d  = T_MEM;
                        end
                        MODE_ABS: begin
                            pc_d    = pc_q + AW'(1);
                            addr_d  = pc_q + AW'(1);
                            state_d = T3_ADDRH;
                        end
                        default: begin
                            // implied, dummy read of the next byte
                            exec_c  = 1'b1;
                            addr_d  = pc_q;
                            state_d = T1_FETCH;
                        end
                    endcase
                end
            end
            T3_ADDRH: begin
                exec_c   = is_store;
                wr_start = is_store;
                pc_d     = pc_q + AW'(1);
                addr_d   = {data_i, adl_q};
                state_d  = T_MEM;
            end
            T_MEM: begin
                // operand arrives here for reads
                exec_c  = is_read;
                addr_d  = pc_q;
                state_d = T1_FETCH;
            end
            T_JAM: state_d = T_JAM;
            default: state_d = T_JAM;
        endcase
    end

    // reset parks in a dummy read so the first fetch starts one clock later
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            state_q <= T_MEM;
            pc_q    <= `CORE_RESET_PC;
            addr_q  <= `CORE_RESET_PC;
            rw_q    <= 1'b1;
        end else if (rdy) begin
            state_q <= state_d;
            pc_q    <= pc_d;
            addr_q  <= addr_d;
            rw_q    <= ~wr_start;
        end
    end

    always_ff @(posedge clk_m1) begin
        if (rdy) begin
            if (state_q == T2_OPER) adl_q <= data_i;
            if (wr_start) dor_q <= alu_out_i;
        end
    end

    assign addr_o  = addr_q;
    assign dor_o   = dor_q;
    assign rw_o    = rw_q;
    assign sync_o  = (state_q == T1_FETCH);
    assign fetch_o = (state_q == T1_FETCH);
    // no strobe while a read cycle repeats
    assign exec_o  = exec_c & rdy;
    assign jam_o   = (state_q == T_JAM);

endmodule

// File: source/core_decode.sv
`include "core_config.svh"

module core_decode
    import core_pkg::*;
(
    input  logic                    clk_m1,
    input  logic                    rst,
    input  logic [`CORE_DATA_W-1:0] data_i,
    input  logic                    ready_i,
    input  logic                    fetch_i,
    core_ctrl_if.decode             ctrl
);

    localparam logic [`CORE_DATA_W-1:0] OP_NOP = 8'hEA;

    logic [`CORE_DATA_W-1:0] ir_q;
    // classic aaa_bbb_cc opcode split
    logic [2:0]              aaa;
    logic [2:0]              bbb;
    logic [1:0]              cc;
    addr_mode_t              grp_mode;
    reg_sel_t                grp_reg;
    alu_op_t                 grp_alu;
    logic                    grp_ok;

    // opcode latched at the end of the sync cycle
    // a stalled fetch keeps the old opcode
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            ir_q <= OP_NOP;
        end else if (fetch_i && ready_i) begin
            ir_q <= data_i;
        end
    end

    assign aaa = ir_q[7:5];
    assign bbb = ir_q[4:2];
    assign cc  = ir_q[1:0];

    // fields shared by the load/store/alu groups
    always_comb begin
        grp_ok = (cc != 2'b11);
        case (bbb)
            3'b000: begin
                // imm for LDX/LDY, (zp,x) for the A group
                grp_mode = MODE_IMM;
                if (cc == 2'b01) grp_ok = 1'b0;
            end
            3'b001: grp_mode = MODE_ZPG;
            3'b010: begin
                // imm only in the A group
                grp_mode = MODE_IMM;
                if (cc != 2'b01) grp_ok = 1'b0;
            end
            3'b011: grp_mode = MODE_ABS;
            default: begin
                grp_mode = MODE_IMPL;
                grp_ok   = 1'b0;
            end
        endcase
        case (cc)
            2'b01:   grp_reg = REG_A;
            2'b10:   grp_reg = REG_X;
            default: grp_reg = REG_Y;
        endcase
        case (aaa)
            3'b000:  grp_alu = ALU_ORA;
            3'b001:  grp_alu = ALU_AND;
            3'b010:  grp_alu = ALU_EOR;
            3'b011:  grp_alu = ALU_ADC;
            3'b111:  grp_alu = ALU_SBC;
            default: grp_alu = ALU_PASS;
        endcase
    end

    always_comb begin
        ctrl.mode        = MODE_IMPL;
        ctrl.op_class    = CLS_NOP;
        ctrl.alu_op      = ALU_PASS;
        ctrl.src         = REG_NONE;
        ctrl.dst         = REG_NONE;
        ctrl.carry_set   = 1'b0;
        ctrl.carry_clear = 1'b0;
        ctrl.jam         = 1'b0;
        case (ir_q)
            OP_NOP: ctrl.op_class = CLS_NOP;
            // CLC
            8'h18: begin
                ctrl.op_class    = CLS_FLAG;
                ctrl.carry_clear = 1'b1;
            end
            // SEC
            8'h38: begin
                ctrl.op_class  = CLS_FLAG;
                ctrl.carry_set = 1'b1;
            end
            // transfers pass src straight to dst
            8'hAA, 8'hA8: begin
                ctrl.op_class = CLS_XFER;
                ctrl.src      = REG_A;
                ctrl.dst      = (ir_q == 8'hAA) ? REG_X : REG_Y;
            end
            8'h8A, 8'h98: begin
                ctrl.op_class = CLS_XFER;
                ctrl.src      = (ir_q == 8'h8A) ? REG_X : REG_Y;
                ctrl.dst      = REG_A;
            end
            // INX INY DEX DEY
            8'hE8, 8'hC8, 8'hCA, 8'h88: begin
                ctrl.op_class = CLS_ALU;
                ctrl.alu_op   = (ir_q == 8'hE8 || ir_q == 8'hC8) ? ALU_INC : ALU_DEC;
                ctrl.src      = (ir_q == 8'hE8 || ir_q == 8'hCA) ? REG_X : REG_Y;
                ctrl.dst      = (ir_q == 8'hE8 || ir_q == 8'hCA) ? REG_X : REG_Y;
            end
            default: begin
                ctrl.mode = grp_mode;
                if (!grp_ok) begin
                    ctrl.jam = 1'b1;
                end else if (aaa == 3'b101) begin
                    ctrl.op_class = CLS_LOAD;
                    ctrl.dst      = grp_reg;
                end else if (aaa == 3'b100 && grp_mode != MODE_IMM) begin
                    ctrl.op_class = CLS_STORE;
                    ctrl.src      = grp_reg;
                end else if (cc == 2'b01 && grp_alu != ALU_PASS) begin
                    // no ALU op for CMP or STA #
                    ctrl.op_class = CLS_ALU;
                    ctrl.alu_op   = grp_alu;
                    ctrl.src      = REG_A;
                    ctrl.dst      = REG_A;
                end else begin
                    ctrl.jam = 1'b1;
                end
            end
        endcase
    end

endmodule

// File: source/core_result_if.sv
`include "core_config.svh"

interface core_result_if
    import core_pkg::*;
();

    // write-back request, one clock after exec
    logic                    wb_valid;
    reg_sel_t                wb_dst;
    logic [`CORE_DATA_W-1:0] wb_value;
    logic                    wb_carry_en;
    logic                    wb_carry;

    // current register file contents
    logic [`CORE_DATA_W-1:0] reg_a;
    logic [`CORE_DATA_W-1:0] reg_x;
    logic [`CORE_DATA_W-1:0] reg_y;
    logic                    carry;

    modport execute (
        output wb_valid, wb_dst, wb_value, wb_carry_en, wb_carry,
        input  reg_a, reg_x, reg_y, carry
    );

    modport result (
        input  wb_valid, wb_dst, wb_value, wb_carry_en, wb_carry,
        output reg_a, reg_x, reg_y, carry
    );

endinterface

// File: source/core_ctrl_if.sv
`include "core_config.svh"

interface core_ctrl_if
    import core_pkg::*;
();

    // decoded fields of the instruction in the IR
    addr_mode_t mode;
    op_class_t  op_class;
    alu_op_t    alu_op;
    reg_sel_t   src;
    reg_sel_t   dst;
    // CLC / SEC
    logic       carry_set;
    logic       carry_clear;
    // opcode outside the kept subset
    logic       jam;

    modport decode (
        output mode, op_class, alu_op, src, dst, carry_set, carry_clear, jam
    );

    // bus sequencing only needs the mode and the read/write nature
    modport timing (
        input mode, op_class, jam
    );

    modport execute (
        input alu_op, src, dst, carry_set, carry_clear
    );

endinterface

// File: source/core_pkg.sv
package core_pkg;

    // where the operand of an instruction comes from
    typedef enum logic [1:0] {
        MODE_IMPL,
        MODE_IMM,
        MODE_ZPG,
        MODE_ABS
    } addr_mode_t;

    // instruction group
    // timing only cares whether the memory cycle reads or writes
    typedef enum logic [2:0] {
        CLS_LOAD,
        CLS_STORE,
        CLS_ALU,
        CLS_XFER,
        CLS_FLAG,
        CLS_NOP
    } op_class_t;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADC,
        ALU_SBC,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_INC,
        ALU_DEC
    } alu_op_t;

    // operand source or write-back target
    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y,
        REG_NONE
    } reg_sel_t;

    // bus cycle inside one instruction
    typedef enum logic [2:0] {
        T1_FETCH,
        T2_OPER,
        T3_ADDRH,
        T_MEM,
        T_JAM
    } cycle_t;

endpackage

// File: source/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// first opcode address once reset is released
`define CORE_RESET_PC 16'h0200

// external bus widths
`define CORE_ADDR_W 16
`define CORE_DATA_W 8

`endif
